// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sample_link_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/link_pkg.sv ====
// Shared types of the sample link
// Settings bus, serial control and serial word structs, framer states
`default_nettype none
`include "link_settings.svh"

package link_pkg;

   typedef logic [`LINK_SET_ADDR_W-1:0] set_addr_t;
   typedef logic [`LINK_SET_DATA_W-1:0] set_data_t;
   typedef logic [`LINK_SAMPLE_W-1:0]   sample_t;
   typedef logic [`LINK_WORD_W-1:0]     ser_word_t;
   typedef logic [7:0]                  led_t;

   // One-cycle write, no acknowledge
   typedef struct packed {
      logic      strobe;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   typedef struct packed {
      logic enable;                     // Serial transmitter on
      logic rx_en;                      // Receiver enable pin
   } serdes_ctrl_t;

   typedef struct packed {
      ser_word_t data;
      logic      klsb;                  // Low byte is a K character
      logic      kmsb;                  // High byte is a K character
   } ser_tx_t;

   typedef enum logic {
      IDLE,
      SEND
   } framer_state_e;

endpackage

`default_nettype wire

// ==== design/link_settings.svh ====
// Settings bus addresses, datapath widths and FIFO depth
// Idle comma and LED reset value for the sample link
`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

////////////////////////////////////////
// Bus and datapath widths
////////////////////////////////////////
`define LINK_SET_ADDR_W     8
`define LINK_SET_DATA_W     32
`define LINK_SAMPLE_W       32          // Packed I/Q, I in the upper half
`define LINK_WORD_W         16
`define LINK_FIFO_AW        4           // 16 words, 8 samples

////////////////////////////////////////
// Settings register map
////////////////////////////////////////
`define LINK_SR_SERDES      1           // Bit 3 enable, bit 0 rx_en
`define LINK_SR_LED_SW      3
`define LINK_SR_LED_SRC     8           // 1 selects the hardware bit
`define LINK_SR_OVF_CLR     9           // Any write clears overflow

`define LINK_LED_SRC_RESET  8'b0001_1110

// K28.5 in the low byte, D16.2 in the high byte
`define LINK_IDLE_WORD      16'h50BC

`endif

// ==== design/sample_link_core.sv ====
// Sample link top level
// Settings decode, sample word FIFO and serial framer
`timescale 1ns/100ps
`default_nettype none
`include "link_settings.svh"

module sample_link_core
   import link_pkg::*;
(
   input  logic         dsp_clk,
   input  logic         por_rst,
   input  set_bus_t     set_i,
   input  sample_t      sample_i,
   input  logic         sample_stb_i,
   input  logic         run_tx_i,
   output ser_tx_t      ser_tx_o,
   output serdes_ctrl_t serdes_ctrl_o,
   output led_t         leds_o
);

   serdes_ctrl_t serdes_ctrl;
   logic         ovf;
   logic         ovf_clr;
   logic         pop;
   ser_word_t    word;
   logic         word_valid;

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////
   settings_decoder u_settings_decoder (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_i         (set_i),
      .ovf_i         (ovf),
      .run_tx_i      (run_tx_i),
      .serdes_ctrl_o (serdes_ctrl),
      .ovf_clr_o     (ovf_clr),
      .leds_o        (leds_o)
   );

   assign serdes_ctrl_o = serdes_ctrl;

   ////////////////////////////////////////
   // Execute
   ////////////////////////////////////////
   sample_word_fifo #(
      .FIFO_AW (`LINK_FIFO_AW)
   ) u_sample_word_fifo (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .sample_i     (sample_i),
      .sample_stb_i (sample_stb_i),
      .run_tx_i     (run_tx_i),
      .ovf_clr_i    (ovf_clr),
      .pop_i        (pop),
      .word_o       (word),
      .word_valid_o (word_valid),
      .ovf_o        (ovf)
   );

   ////////////////////////////////////////
   // Result
   ////////////////////////////////////////
   serdes_framer u_serdes_framer (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .ctrl_i       (serdes_ctrl),
      .word_i       (word),
      .word_valid_i (word_valid),
      .pop_o        (pop),
      .ser_tx_o     (ser_tx_o)
   );

endmodule

`default_nettype wire

// ==== design/sample_word_fifo.sv ====
// Gated 32-bit sample capture into a 16-bit word FIFO
// Occupancy counter, drop on full and sticky overflow flag
`timescale 1ns/100ps
`default_nettype none
`include "link_settings.svh"

module sample_word_fifo
   import link_pkg::*;
#(
   parameter int FIFO_AW = `LINK_FIFO_AW
) (
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  sample_t   sample_i,
   input  logic      sample_stb_i,
   input  logic      run_tx_i,
   input  logic      ovf_clr_i,
   input  logic      pop_i,
   output ser_word_t word_o,
   output logic      word_valid_o,
   output logic      ovf_o
);

   localparam int DEPTH = 2 ** FIFO_AW;

   typedef logic [FIFO_AW-1:0] ptr_t;
   typedef logic [FIFO_AW:0]   occ_t;    // One extra bit to hold DEPTH

   ser_word_t mem [DEPTH];
   ptr_t      wr_ptr;
   ptr_t      rd_ptr;
   occ_t      occ;

   ////////////////////////////////////////
   // Accept or drop
   ////////////////////////////////////////
   logic room;
   logic capture;
   logic accept;
   logic drop;

   assign room    = (occ <= occ_t'(DEPTH - 2));   // Both halves must fit
   assign capture = sample_stb_i && !run_tx_i;    // No capture while transmitting
   assign accept  = capture && room;
   assign drop    = capture && !room;

   // Upper half goes first so it leaves first
   always_ff @(posedge dsp_clk) begin
      if (accept) begin
         mem[wr_ptr]              <= sample_i[`LINK_SAMPLE_W-1:`LINK_WORD_W];
         mem[wr_ptr + ptr_t'(1)]  <= sample_i[`LINK_WORD_W-1:0];
      end
   end

   ////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////
   occ_t occ_add;
   occ_t occ_sub;

   assign occ_add = accept ? occ_t'(2) : occ_t'(0);
   assign occ_sub = pop_i ? occ_t'(1) : occ_t'(0);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ    <= '0;
      end else begin
         if (accept) begin
            wr_ptr <= wr_ptr + ptr_t'(2);
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
         occ <= occ + occ_add - occ_sub;
      end
   end

   assign word_o       = mem[rd_ptr];
   assign word_valid_o = (occ != '0);

   ////////////////////////////////////////
   // Sticky overflow
   ////////////////////////////////////////
   logic ovf_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ovf_q <= 1'b0;
      end else begin
         ovf_q <= (ovf_q && !ovf_clr_i) || drop;  // A drop beats a clear in the same cycle
      end
   end

   assign ovf_o = ovf_q;

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   a_no_pop_empty: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      pop_i |-> (occ != '0)
   );

   a_occ_bound: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      occ <= occ_t'(DEPTH)
   );

endmodule

`default_nettype wire

// ==== design/serdes_framer.sv ====
// Serial word framer
// Pops FIFO words when enabled, sends the idle comma otherwise
`timescale 1ns/100ps
`default_nettype none
`include "link_settings.svh"

module serdes_framer
   import link_pkg::*;
(
   input  logic         dsp_clk,
   input  logic         por_rst,
   input  serdes_ctrl_t ctrl_i,
   input  ser_word_t    word_i,
   input  logic         word_valid_i,
   output logic         pop_o,
   output ser_tx_t      ser_tx_o
);

   framer_state_e state_q;
   ser_word_t     data_q;

   // At most one word per cycle, never on an empty FIFO
   assign pop_o = ctrl_i.enable && word_valid_i;

   ////////////////////////////////////////
   // State and data register
   ////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q <= IDLE;
      end else if (pop_o) begin
         state_q <= SEND;
      end else begin
         state_q <= IDLE;               // Nothing to send this cycle
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (pop_o) begin
         data_q <= word_i;
      end
   end

   ////////////////////////////////////////
   // Output word
   ////////////////////////////////////////
   always_comb begin
      case (state_q)
         SEND: begin
            ser_tx_o.data = data_q;
            ser_tx_o.klsb = 1'b0;
            ser_tx_o.kmsb = 1'b0;
         end
         default: begin
            ser_tx_o.data = `LINK_IDLE_WORD;   // Comma keeps the link aligned
            ser_tx_o.klsb = 1'b1;
            ser_tx_o.kmsb = 1'b0;
         end
      endcase
   end

   // A data word on the line means a pop one cycle before
   a_data_popped: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      (!ser_tx_o.klsb && !ser_tx_o.kmsb) |-> $past(pop_o)
   );

endmodule

`default_nettype wire

// ==== design/settings_decoder.sv ====
// Settings register bank for serial control and LEDs
// Overflow clear pulse and LED source mux
`timescale 1ns/100ps
`default_nettype none
`include "link_settings.svh"

module settings_decoder
   import link_pkg::*;
(
   input  logic         dsp_clk,
   input  logic         por_rst,
   input  set_bus_t     set_i,
   input  logic         ovf_i,
   input  logic         run_tx_i,
   output serdes_ctrl_t serdes_ctrl_o,
   output logic         ovf_clr_o,
   output led_t         leds_o
);

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////
   logic wr_serdes;
   logic wr_led_sw;
   logic wr_led_src;
   logic wr_ovf_clr;

   assign wr_serdes  = set_i.strobe && (set_i.addr == set_addr_t'(`LINK_SR_SERDES));
   assign wr_led_sw  = set_i.strobe && (set_i.addr == set_addr_t'(`LINK_SR_LED_SW));
   assign wr_led_src = set_i.strobe && (set_i.addr == set_addr_t'(`LINK_SR_LED_SRC));
   assign wr_ovf_clr = set_i.strobe && (set_i.addr == set_addr_t'(`LINK_SR_OVF_CLR));

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////
   serdes_ctrl_t serdes_ctrl_q;
   led_t         led_sw_q;
   led_t         led_src_q;
   logic         ovf_clr_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         serdes_ctrl_q <= '0;
         led_sw_q      <= '0;
         led_src_q     <= `LINK_LED_SRC_RESET;
         ovf_clr_q     <= 1'b0;
      end else begin
         if (wr_serdes) begin
            // Prbs and loopback bits 2:1 are not kept
            serdes_ctrl_q.enable <= set_i.data[3];
            serdes_ctrl_q.rx_en  <= set_i.data[0];
         end
         if (wr_led_sw) begin
            led_sw_q <= set_i.data[7:0];
         end
         if (wr_led_src) begin
            led_src_q <= set_i.data[7:0];
         end
         ovf_clr_q <= wr_ovf_clr;       // Single-cycle pulse per write
      end
   end

   assign serdes_ctrl_o = serdes_ctrl_q;
   assign ovf_clr_o     = ovf_clr_q;

   ////////////////////////////////////////
   // LED source mux
   ////////////////////////////////////////
   led_t led_hw;

   assign led_hw = {3'b000, run_tx_i, ovf_i, serdes_ctrl_q.enable, 2'b00};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   // Back-to-back clear pulses need back-to-back strobes
   a_clr_pulse: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      (ovf_clr_o && $past(ovf_clr_o)) |-> ($past(set_i.strobe) && $past(set_i.strobe, 2))
   );

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/link_pkg.sv
design/settings_decoder.sv
design/sample_word_fifo.sv
design/serdes_framer.sv
design/sample_link_core.sv
verif/tb_sample_link_core.sv

// ==== verif/tb_sample_link_core.sv ====
// Testbench for the sample link core
// Random settings writes and samples checked against a cycle model
`timescale 1ns/100ps
`default_nettype none
`include "link_settings.svh"

module tb_sample_link_core
   import link_pkg::*;
();

   localparam int DEPTH          = 2 ** `LINK_FIFO_AW;
   localparam int N_WRITES       = 200;
   localparam int N_STREAM       = 300;
   localparam int N_RUNTX        = 60;
   localparam int N_FILL         = 12;
   localparam int N_FIXED        = 120;   // Reset, setup writes and drains
   localparam int STIM_CYCLES    = N_WRITES + N_STREAM + N_RUNTX + N_FILL + N_FIXED;
   localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

   logic         dsp_clk;
   logic         por_rst;
   set_bus_t     set_bus;
   sample_t      sample;
   logic         sample_stb;
   logic         run_tx;
   ser_tx_t      ser_tx;
   serdes_ctrl_t serdes_ctrl;
   led_t         leds;

   // Reference model state
   logic [15:0]  fifo_q [$];
   logic         m_en;
   logic         m_rx_en;
   led_t         m_led_sw;
   led_t         m_led_src;
   logic         m_clr;
   logic         m_ovf;
   logic         m_send;
   logic [15:0]  m_data;

   integer       seed;
   int           cycle_cnt;
   int           data_words;

   sample_link_core u_sample_link_core (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_i         (set_bus),
      .sample_i      (sample),
      .sample_stb_i  (sample_stb),
      .run_tx_i      (run_tx),
      .ser_tx_o      (ser_tx),
      .serdes_ctrl_o (serdes_ctrl),
      .leds_o        (leds)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #50 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
      if (got !== exp) begin
         $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   // Source bit 1 shows the hardware bit
   function automatic led_t led_expect(led_t src, led_t sw, logic rt, logic ovf, logic en);
      led_t hw;
      led_t leds_exp;
      hw = 8'h00;
      hw[4] = rt;
      hw[3] = ovf;
      hw[2] = en;
      for (int b = 0; b < 8; b++)
         leds_exp[b] = src[b] ? hw[b] : sw[b];
      return leds_exp;
   endfunction

   task automatic drive_cycle(input set_bus_t s, input logic stb, input sample_t smp,
                              input logic rt);
      @(posedge dsp_clk);
      set_bus    <= s;
      sample_stb <= stb;
      sample     <= smp;
      run_tx     <= rt;
   endtask

   task automatic write_reg(input set_addr_t addr, input set_data_t data);
      set_bus_t s;
      s.strobe = 1'b1;
      s.addr   = addr;
      s.data   = data;
      drive_cycle(s, 1'b0, '0, 1'b0);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle('0, 1'b0, '0, 1'b0);
   endtask

   ////////////////////////////////////////
   // Cycle model and output compare
   ////////////////////////////////////////
   always @(posedge dsp_clk) begin : model_update
      logic pop;
      logic capture;
      logic room;
      if (por_rst) begin
         fifo_q.delete();
         m_en      = 1'b0;
         m_rx_en   = 1'b0;
         m_led_sw  = '0;
         m_led_src = `LINK_LED_SRC_RESET;
         m_clr     = 1'b0;
         m_ovf     = 1'b0;
         m_send    = 1'b0;
         m_data    = '0;
      end else begin
         pop     = m_en && (fifo_q.size() != 0);
         capture = sample_stb && !run_tx;
         room    = (fifo_q.size() <= DEPTH - 2);   // Room for both halves
         m_ovf   = (m_ovf && !m_clr) || (capture && !room);
         m_clr   = set_bus.strobe && (set_bus.addr == set_addr_t'(`LINK_SR_OVF_CLR));
         if (set_bus.strobe && (set_bus.addr == set_addr_t'(`LINK_SR_SERDES))) begin
            m_en    = set_bus.data[3];
            m_rx_en = set_bus.data[0];
         end
         if (set_bus.strobe && (set_bus.addr == set_addr_t'(`LINK_SR_LED_SW)))
            m_led_sw = set_bus.data[7:0];
         if (set_bus.strobe && (set_bus.addr == set_addr_t'(`LINK_SR_LED_SRC)))
            m_led_src = set_bus.data[7:0];
         m_send = pop;
         if (pop)
            m_data = fifo_q.pop_front();
         if (capture && room) begin
            fifo_q.push_back(sample[31:16]);      // Upper half leaves first
            fifo_q.push_back(sample[15:0]);
         end
      end
   end

   always @(negedge dsp_clk) begin : output_check
      ser_tx_t exp_tx;
      if (!por_rst) begin
         exp_tx.data = m_send ? m_data : `LINK_IDLE_WORD;
         exp_tx.klsb = !m_send;
         exp_tx.kmsb = 1'b0;
         expect_equal(64'(ser_tx), 64'(exp_tx), "serial output");
         expect_equal(64'(serdes_ctrl), 64'({m_en, m_rx_en}), "serdes control");
         expect_equal(64'(leds), 64'(led_expect(m_led_src, m_led_sw, run_tx, m_ovf, m_en)),
                      "LEDs");
         if (!ser_tx.klsb && !ser_tx.kmsb)
            data_words++;
      end
   end

   always @(posedge dsp_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $fatal(1, "Simulation timed out");
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   initial begin
      set_bus_t    s;
      logic [31:0] rnd;
      logic        stb;
      logic        prev_stb;
      int          words_before;
      seed       = 32'hf6ae6aad;
      cycle_cnt  = 0;
      data_words = 0;
      por_rst    = 1'b1;
      set_bus    = '0;
      sample     = '0;
      sample_stb = 1'b0;
      run_tx     = 1'b0;
      repeat (8) @(posedge dsp_clk);
      por_rst <= 1'b0;

      // Reset state
      @(negedge dsp_clk);
      expect_equal(64'(ser_tx), 64'({`LINK_IDLE_WORD, 1'b1, 1'b0}), "idle after reset");
      expect_equal(64'(serdes_ctrl), 64'd0, "control after reset");
      expect_equal(64'(leds), 64'(`LINK_LED_SRC_RESET & 8'h00), "LEDs after reset");

      // Random register writes to low addresses that often hit the map
      for (int i = 0; i < N_WRITES; i++) begin
         rnd      = $random(seed);
         s.strobe = rnd[0] | rnd[1];
         s.addr   = set_addr_t'(rnd[7:4]);
         s.data   = $random(seed);
         drive_cycle(s, 1'b0, '0, rnd[2]);
      end

      write_reg(set_addr_t'(`LINK_SR_SERDES), 32'h9);
      write_reg(set_addr_t'(`LINK_SR_LED_SRC), set_data_t'(`LINK_LED_SRC_RESET));
      write_reg(set_addr_t'(`LINK_SR_OVF_CLR), 32'h0);

      // Streaming with never two strobes in a row
      prev_stb = 1'b0;
      for (int i = 0; i < N_STREAM; i++) begin
         rnd = $random(seed);
         stb = rnd[0] && !prev_stb;
         drive_cycle('0, stb, sample_t'($random(seed)), 1'b0);
         prev_stb = stb;
      end
      idle_cycles(8);

      words_before = data_words;
      for (int i = 0; i < N_RUNTX; i++)
         drive_cycle('0, (i % 2) == 0, sample_t'($random(seed)), 1'b1);
      idle_cycles(8);
      expect_equal(64'(data_words - words_before), 64'd0, "data words while run_tx high");

      // Fill with the link off until samples drop
      write_reg(set_addr_t'(`LINK_SR_SERDES), 32'h0);
      for (int i = 0; i < N_FILL; i++)
         drive_cycle('0, 1'b1, sample_t'($random(seed)), 1'b0);
      idle_cycles(2);
      words_before = data_words;
      @(negedge dsp_clk);
      expect_equal(64'(leds[3]), 64'd1, "overflow LED after fill");
      write_reg(set_addr_t'(`LINK_SR_SERDES), 32'h9);
      idle_cycles(24);
      expect_equal(64'(data_words - words_before), 64'(DEPTH), "words after overflow");

      write_reg(set_addr_t'(`LINK_SR_OVF_CLR), 32'h0);
      idle_cycles(2);                            // Clear pulse, then flag drops
      @(negedge dsp_clk);
      expect_equal(64'(leds[3]), 64'd0, "overflow LED after clear");

      idle_cycles(4);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire
